//--- decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

`define DEC_XLEN        32
`define DEC_NUM_WARPS   4
`define DEC_NUM_THREADS 4
`define DEC_UUID_W      16

// Major opcodes
`define DEC_OPC_LUI     7'b0110111
`define DEC_OPC_AUIPC   7'b0010111
`define DEC_OPC_JAL     7'b1101111
`define DEC_OPC_JALR    7'b1100111
`define DEC_OPC_B       7'b1100011
`define DEC_OPC_L       7'b0000011
`define DEC_OPC_S       7'b0100011
`define DEC_OPC_I       7'b0010011
`define DEC_OPC_R       7'b0110011
`define DEC_OPC_FENCE   7'b0001111
`define DEC_OPC_SYS     7'b1110011
`define DEC_OPC_EXT1    7'b0001011  // Warp control (custom-0)

// System call funct12 codes
`define DEC_F12_ECALL   12'h000
`define DEC_F12_EBREAK  12'h001
`define DEC_F12_URET    12'h002
`define DEC_F12_SRET    12'h102
`define DEC_F12_MRET    12'h302

`endif

//--- src/decode_pkg.sv
`include "decode_cfg.svh"

package decode_pkg;

    typedef logic [31:0]                          instr_t;
    typedef logic [`DEC_XLEN-1:0]                 word_t;
    typedef logic [4:0]                           reg_num_t;
    typedef logic [$clog2(`DEC_NUM_WARPS)-1:0]    wid_t;
    typedef logic [`DEC_NUM_THREADS-1:0]          tmask_t;
    typedef logic [`DEC_UUID_W-1:0]               uuid_t;
    typedef logic [3:0]                           op_t;

    typedef enum logic [1:0] {
        EX_ALU,
        EX_LSU,
        EX_SFU
    } ex_type_e;

    typedef enum logic {
        ALU_ARITH,
        ALU_BRANCH
    } alu_xtype_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR,
        BR_ECALL, BR_EBREAK, BR_URET, BR_SRET, BR_MRET
    } br_op_e;

    // Warp control ops follow funct3 order, CSR ops follow funct3[1:0]
    typedef enum logic [3:0] {
        SFU_TMC, SFU_WSPAWN, SFU_SPLIT, SFU_JOIN, SFU_BAR, SFU_PRED,
        SFU_CSRRW, SFU_CSRRS, SFU_CSRRC
    } sfu_op_e;

    localparam op_t LSU_FENCE = 4'hF;  // Loads/stores use {is_store, funct3}

    typedef struct packed {
        word_t      imm;       // ALU imm, LSU offset or CSR imm
        logic       use_imm;
        logic       use_pc;
        alu_xtype_e xtype;
        logic       is_store;
        logic [11:0] csr_addr;
        logic       is_neg;    // SPLIT/PRED predicate inversion
    } op_args_t;

    typedef struct packed {
        uuid_t  uuid;
        wid_t   wid;
        tmask_t tmask;
        word_t  pc;
        instr_t instr;
    } fetch_t;

    typedef struct packed {
        uuid_t    uuid;
        wid_t     wid;
        tmask_t   tmask;
        word_t    pc;
        ex_type_e ex_type;
        op_t      op_type;
        op_args_t op_args;
        logic     wb;
        logic [1:0] used_rs;   // {rs2, rs1}
        reg_num_t rd;
        reg_num_t rs1;
        reg_num_t rs2;
    } decode_t;

    typedef struct packed {
        wid_t wid;
        logic unlock;
    } sched_t;

endpackage

//--- src/imm_gen.sv
`timescale 1ns/1ns
`include "decode_cfg.svh"

module imm_gen import decode_pkg::*; (
    input  instr_t instr,
    output word_t  imm
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [12:0] b_imm;
    logic [20:0] j_imm;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign i_imm  = instr[31:20];
    assign s_imm  = {instr[31:25], instr[11:7]};
    assign b_imm  = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm  = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (opcode)
            `DEC_OPC_I: begin
                if (funct3[1:0] == 2'b01)
                    imm = word_t'(instr[24:20]);  // Shift amount only
                else
                    imm = {{(`DEC_XLEN-12){i_imm[11]}}, i_imm};
            end
            `DEC_OPC_JALR,
            `DEC_OPC_L:     imm = {{(`DEC_XLEN-12){i_imm[11]}}, i_imm};
            `DEC_OPC_S:     imm = {{(`DEC_XLEN-12){s_imm[11]}}, s_imm};
            `DEC_OPC_B:     imm = {{(`DEC_XLEN-13){b_imm[12]}}, b_imm};
            `DEC_OPC_JAL:   imm = {{(`DEC_XLEN-21){j_imm[20]}}, j_imm};
            `DEC_OPC_LUI,
            `DEC_OPC_AUIPC: imm = word_t'({instr[31:12], 12'h000});
            `DEC_OPC_SYS: begin
                // CSR immediate is the rs1 field, system calls link pc+4
                imm = (funct3[1:0] != 2'b00) ? word_t'(instr[19:15]) : word_t'(4);
            end
            default:        imm = '0;
        endcase
    end

endmodule

//--- src/alu_op_decoder.sv
`timescale 1ns/1ns
`include "decode_cfg.svh"

module alu_op_decoder import decode_pkg::*; (
    input  instr_t instr,
    output op_t    alu_op,
    output op_t    br_op,
    output op_t    sys_op
);

    logic [2:0]  funct3;
    logic [11:0] funct12;
    logic        alt;      // funct7[5]
    logic        is_rtype;

    assign funct3   = instr[14:12];
    assign funct12  = instr[31:20];
    assign alt      = instr[30];
    assign is_rtype = (instr[6:0] == `DEC_OPC_R);

    always_comb begin
        case (funct3)
            3'h0:    alu_op = (is_rtype && alt) ? op_t'(ALU_SUB) : op_t'(ALU_ADD);
            3'h1:    alu_op = op_t'(ALU_SLL);
            3'h2:    alu_op = op_t'(ALU_SLT);
            3'h3:    alu_op = op_t'(ALU_SLTU);
            3'h4:    alu_op = op_t'(ALU_XOR);
            3'h5:    alu_op = alt ? op_t'(ALU_SRA) : op_t'(ALU_SRL);
            3'h6:    alu_op = op_t'(ALU_OR);
            default: alu_op = op_t'(ALU_AND);
        endcase
    end

    always_comb begin
        case (funct3)
            3'h1:    br_op = op_t'(BR_BNE);
            3'h4:    br_op = op_t'(BR_BLT);
            3'h5:    br_op = op_t'(BR_BGE);
            3'h6:    br_op = op_t'(BR_BLTU);
            3'h7:    br_op = op_t'(BR_BGEU);
            default: br_op = op_t'(BR_BEQ);  // Reserved codes filtered upstream
        endcase
    end

    always_comb begin
        case (funct12)
            `DEC_F12_EBREAK: sys_op = op_t'(BR_EBREAK);
            `DEC_F12_URET:   sys_op = op_t'(BR_URET);
            `DEC_F12_SRET:   sys_op = op_t'(BR_SRET);
            `DEC_F12_MRET:   sys_op = op_t'(BR_MRET);
            default:         sys_op = op_t'(BR_ECALL);
        endcase
    end

endmodule

//--- src/instr_decoder.sv
`timescale 1ns/1ns
`include "decode_cfg.svh"

module instr_decoder import decode_pkg::*; (
    input  fetch_t  fetch_data,
    output decode_t dec_data,
    output logic    unlock
);

    instr_t      instr;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    reg_num_t    rd_f;
    reg_num_t    rs1_f;
    reg_num_t    rs2_f;

    word_t    imm;
    op_t      alu_op;
    op_t      br_op;
    op_t      sys_op;

    ex_type_e ex_type;
    op_t      op_type;
    op_args_t op_args;
    logic     use_rd;
    logic     use_rs1;
    logic     use_rs2;
    logic     is_wstall;
    logic     sys_call_ok;

    assign instr   = fetch_data.instr;
    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign funct12 = instr[31:20];
    assign rd_f    = instr[11:7];
    assign rs1_f   = instr[19:15];
    assign rs2_f   = instr[24:20];

    assign sys_call_ok = (funct3 == 3'h0) &&
                         (funct12 == `DEC_F12_ECALL || funct12 == `DEC_F12_EBREAK ||
                          funct12 == `DEC_F12_URET  || funct12 == `DEC_F12_SRET ||
                          funct12 == `DEC_F12_MRET);

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    alu_op_decoder u_alu_op_decoder (
        .instr  (instr),
        .alu_op (alu_op),
        .br_op  (br_op),
        .sys_op (sys_op)
    );

    always_comb begin
        // Anything not matched below stays a plain ADD with no side effects
        ex_type   = EX_ALU;
        op_type   = op_t'(ALU_ADD);
        op_args   = '0;
        use_rd    = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        is_wstall = 1'b0;

        case (opcode)
            `DEC_OPC_R: begin
                if (funct7 == 7'h00 || (funct7 == 7'h20 && funct3 inside {3'h0, 3'h5})) begin
                    op_type = alu_op;
                    {use_rd, use_rs1, use_rs2} = 3'b111;
                end
            end
            `DEC_OPC_I: begin
                op_type = alu_op;
                op_args.use_imm = 1'b1;
                op_args.imm     = imm;
                {use_rd, use_rs1} = 2'b11;
            end
            `DEC_OPC_LUI, `DEC_OPC_AUIPC: begin
                op_type = (opcode == `DEC_OPC_LUI) ? op_t'(ALU_LUI) : op_t'(ALU_AUIPC);
                op_args.use_imm = 1'b1;
                op_args.use_pc  = (opcode == `DEC_OPC_AUIPC);
                op_args.imm     = imm;
                use_rd = 1'b1;
            end
            `DEC_OPC_JAL, `DEC_OPC_JALR: begin
                op_type = (opcode == `DEC_OPC_JAL) ? op_t'(BR_JAL) : op_t'(BR_JALR);
                op_args.xtype   = ALU_BRANCH;
                op_args.use_imm = 1'b1;
                op_args.use_pc  = (opcode == `DEC_OPC_JAL);
                op_args.imm     = imm;
                use_rd    = 1'b1;
                use_rs1   = (opcode == `DEC_OPC_JALR);
                is_wstall = 1'b1;
            end
            `DEC_OPC_B: begin
                if (funct3[2:1] != 2'b01) begin
                    op_type = br_op;
                    op_args.xtype   = ALU_BRANCH;
                    op_args.use_imm = 1'b1;
                    op_args.use_pc  = 1'b1;
                    op_args.imm     = imm;
                    {use_rs1, use_rs2} = 2'b11;
                    is_wstall = 1'b1;
                end
            end
            `DEC_OPC_L: begin
                if (funct3 != 3'h3 && funct3[2:1] != 2'b11) begin  // LB..LHU only
                    ex_type = EX_LSU;
                    op_type = {1'b0, funct3};
                    op_args.imm = imm;
                    {use_rd, use_rs1} = 2'b11;
                end
            end
            `DEC_OPC_S: begin
                if (!funct3[2] && funct3 != 3'h3) begin
                    ex_type = EX_LSU;
                    op_type = {1'b1, funct3};
                    op_args.is_store = 1'b1;
                    op_args.imm      = imm;
                    {use_rs1, use_rs2} = 2'b11;
                end
            end
            `DEC_OPC_FENCE: begin
                ex_type = EX_LSU;
                op_type = LSU_FENCE;
            end
            `DEC_OPC_SYS: begin
                if (funct3[1:0] != 2'b00) begin
                    ex_type = EX_SFU;
                    // CSRRW/S/C sit in funct3[1:0] order
                    op_type = op_t'(SFU_CSRRW) + op_t'(funct3[1:0] - 2'd1);
                    op_args.csr_addr = funct12;
                    op_args.use_imm  = funct3[2];
                    op_args.imm      = funct3[2] ? imm : '0;
                    use_rd  = 1'b1;
                    use_rs1 = ~funct3[2];
                end else if (sys_call_ok) begin
                    op_type = sys_op;
                    op_args.xtype   = ALU_BRANCH;
                    op_args.use_imm = 1'b1;
                    op_args.use_pc  = 1'b1;
                    op_args.imm     = imm;
                    use_rd    = 1'b1;
                    is_wstall = 1'b1;
                end
            end
            `DEC_OPC_EXT1: begin
                if (funct7 == 7'h00 && funct3 < 3'h6) begin
                    ex_type   = EX_SFU;
                    op_type   = op_t'(SFU_TMC) + op_t'(funct3);
                    is_wstall = 1'b1;
                    use_rs1   = 1'b1;
                    case (funct3)
                        3'h1, 3'h4: use_rs2 = 1'b1;  // WSPAWN, BAR
                        3'h2: begin                  // SPLIT
                            use_rd = 1'b1;
                            op_args.is_neg = rs2_f[0];
                        end
                        3'h5: begin                  // PRED
                            use_rs2 = 1'b1;
                            op_args.is_neg = rd_f[0];
                        end
                        default: ;
                    endcase
                end
            end
            default: ;
        endcase
    end

    assign dec_data.uuid    = fetch_data.uuid;
    assign dec_data.wid     = fetch_data.wid;
    assign dec_data.tmask   = fetch_data.tmask;
    assign dec_data.pc      = fetch_data.pc;
    assign dec_data.ex_type = ex_type;
    assign dec_data.op_type = op_type;
    assign dec_data.op_args = op_args;
    assign dec_data.wb      = use_rd && (rd_f != '0);  // No write to x0
    assign dec_data.used_rs = {use_rs2, use_rs1};
    assign dec_data.rd      = use_rd  ? rd_f  : '0;
    assign dec_data.rs1     = use_rs1 ? rs1_f : '0;
    assign dec_data.rs2     = use_rs2 ? rs2_f : '0;

    assign unlock = ~is_wstall;

endmodule

//--- src/decode_pipe_reg.sv
`timescale 1ns/1ns

module decode_pipe_reg import decode_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    in_valid,
    input  decode_t in_data,
    input  logic    unlock,
    output logic    in_ready,
    output logic    out_valid,
    output decode_t out_data,
    input  logic    out_ready,
    output logic    sched_valid,
    output sched_t  sched_data
);

    logic fire;

    // Register is free when empty or draining this cycle
    assign in_ready = ~out_valid | out_ready;
    assign fire     = in_valid & in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_data <= in_data;
        end
    end

    // Scheduler notice on acceptance
    assign sched_valid = fire;
    assign sched_data  = '{wid: in_data.wid, unlock: unlock};

endmodule

//--- src/decode_top.sv
`timescale 1ns/1ns

module decode_top import decode_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    fetch_valid,
    input  fetch_t  fetch_data,
    output logic    fetch_ready,
    output logic    decode_valid,
    output decode_t decode_data,
    input  logic    decode_ready,
    output logic    sched_valid,
    output sched_t  sched_data
);

    decode_t dec_data;
    logic    unlock;

    instr_decoder u_instr_decoder (
        .fetch_data (fetch_data),
        .dec_data   (dec_data),
        .unlock     (unlock)
    );

    decode_pipe_reg u_decode_pipe_reg (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (fetch_valid),
        .in_data     (dec_data),
        .unlock      (unlock),
        .in_ready    (fetch_ready),
        .out_valid   (decode_valid),
        .out_data    (decode_data),
        .out_ready   (decode_ready),
        .sched_valid (sched_valid),
        .sched_data  (sched_data)
    );

endmodule

//--- testbench/tb_decode_vectors.svh
// Columns: instruction word, unit, op code, immediate, op_args flags, csr_addr,
//          wb, used_rs {rs2, rs1}, rd, rs1, rs2, unlock
task automatic load_vectors;
    // Integer ALU
    add_row(r_type(7'h00, 5'd3, 5'd2, 3'h0, 5'd1, `DEC_OPC_R), EX_ALU, ALU_ADD, 32'h0,
            5'b0, 12'h000, 1'b1, 2'b11, 5'd1, 5'd2, 5'd3, 1'b1);
    add_row(r_type(7'h20, 5'd7, 5'd6, 3'h0, 5'd5, `DEC_OPC_R), EX_ALU, ALU_SUB, 32'h0,
            5'b0, 12'h000, 1'b1, 2'b11, 5'd5, 5'd6, 5'd7, 1'b1);
    add_row(r_type(7'h20, 5'd10, 5'd9, 3'h5, 5'd8, `DEC_OPC_R), EX_ALU, ALU_SRA, 32'h0,
            5'b0, 12'h000, 1'b1, 2'b11, 5'd8, 5'd9, 5'd10, 1'b1);
    add_row(r_type(7'h01, 5'd3, 5'd2, 3'h0, 5'd1, `DEC_OPC_R), EX_ALU, ALU_ADD, 32'h0,
            5'b0, 12'h000, 1'b0, 2'b00, 5'd0, 5'd0, 5'd0, 1'b1);  // MUL is not decoded
    add_row(i_type(12'hffb, 5'd2, 3'h0, 5'd4, `DEC_OPC_I), EX_ALU, ALU_ADD, 32'hffff_fffb,
            fl_imm, 12'h000, 1'b1, 2'b01, 5'd4, 5'd2, 5'd0, 1'b1);
    add_row(i_type(12'h407, 5'd12, 3'h5, 5'd11, `DEC_OPC_I), EX_ALU, ALU_SRA, 32'd7,
            fl_imm, 12'h000, 1'b1, 2'b01, 5'd11, 5'd12, 5'd0, 1'b1);
    add_row(i_type(12'h7ff, 5'd1, 3'h7, 5'd0, `DEC_OPC_I), EX_ALU, ALU_AND, 32'h7ff,
            fl_imm, 12'h000, 1'b0, 2'b01, 5'd0, 5'd1, 5'd0, 1'b1);
    add_row(u_type(20'habcde, 5'd15, `DEC_OPC_LUI), EX_ALU, ALU_LUI, 32'habcd_e000,
            fl_imm, 12'h000, 1'b1, 2'b00, 5'd15, 5'd0, 5'd0, 1'b1);
    add_row(u_type(20'h80001, 5'd16, `DEC_OPC_AUIPC), EX_ALU, ALU_AUIPC, 32'h8000_1000,
            fl_imm | fl_pc, 12'h000, 1'b1, 2'b00, 5'd16, 5'd0, 5'd0, 1'b1);
    // Control transfer
    add_row(j_type(21'h1f_fff0, 5'd1), EX_ALU, BR_JAL, 32'hffff_fff0,
            fl_imm | fl_pc | fl_br, 12'h000, 1'b1, 2'b00, 5'd1, 5'd0, 5'd0, 1'b0);
    add_row(i_type(12'h008, 5'd1, 3'h0, 5'd0, `DEC_OPC_JALR), EX_ALU, BR_JALR, 32'd8,
            fl_imm | fl_br, 12'h000, 1'b0, 2'b01, 5'd0, 5'd1, 5'd0, 1'b0);
    add_row(b_type(13'h00c, 5'd2, 5'd1, 3'h0), EX_ALU, BR_BEQ, 32'd12,
            fl_imm | fl_pc | fl_br, 12'h000, 1'b0, 2'b11, 5'd0, 5'd1, 5'd2, 1'b0);
    add_row(b_type(13'h1000, 5'd4, 5'd3, 3'h6), EX_ALU, BR_BLTU, 32'hffff_f000,
            fl_imm | fl_pc | fl_br, 12'h000, 1'b0, 2'b11, 5'd0, 5'd3, 5'd4, 1'b0);
    add_row(i_type(12'h000, 5'd0, 3'h0, 5'd0, `DEC_OPC_SYS), EX_ALU, BR_ECALL, 32'd4,
            fl_imm | fl_pc | fl_br, 12'h000, 1'b0, 2'b00, 5'd0, 5'd0, 5'd0, 1'b0);
    add_row(i_type(12'h001, 5'd0, 3'h0, 5'd0, `DEC_OPC_SYS), EX_ALU, BR_EBREAK, 32'd4,
            fl_imm | fl_pc | fl_br, 12'h000, 1'b0, 2'b00, 5'd0, 5'd0, 5'd0, 1'b0);
    add_row(i_type(12'h302, 5'd0, 3'h0, 5'd0, `DEC_OPC_SYS), EX_ALU, BR_MRET, 32'd4,
            fl_imm | fl_pc | fl_br, 12'h000, 1'b0, 2'b00, 5'd0, 5'd0, 5'd0, 1'b0);
    // Memory and CSR
    add_row(i_type(12'hff8, 5'd8, 3'h2, 5'd7, `DEC_OPC_L), EX_LSU, 4'h2, 32'hffff_fff8,
            5'b0, 12'h000, 1'b1, 2'b01, 5'd7, 5'd8, 5'd0, 1'b1);
    add_row(i_type(12'd100, 5'd10, 3'h4, 5'd9, `DEC_OPC_L), EX_LSU, 4'h4, 32'd100,
            5'b0, 12'h000, 1'b1, 2'b01, 5'd9, 5'd10, 5'd0, 1'b1);
    add_row(s_type(12'h014, 5'd11, 5'd12, 3'h2), EX_LSU, 4'ha, 32'd20,
            fl_st, 12'h000, 1'b0, 2'b11, 5'd0, 5'd12, 5'd11, 1'b1);
    add_row(32'h0ff0_000f, EX_LSU, 4'hf, 32'h0,
            5'b0, 12'h000, 1'b0, 2'b00, 5'd0, 5'd0, 5'd0, 1'b1);
    add_row(i_type(12'h300, 5'd6, 3'h1, 5'd5, `DEC_OPC_SYS), EX_SFU, SFU_CSRRW, 32'h0,
            5'b0, 12'h300, 1'b1, 2'b01, 5'd5, 5'd6, 5'd0, 1'b1);
    add_row(i_type(12'hc00, 5'd17, 3'h6, 5'd7, `DEC_OPC_SYS), EX_SFU, SFU_CSRRS, 32'd17,
            fl_imm, 12'hc00, 1'b1, 2'b00, 5'd7, 5'd0, 5'd0, 1'b1);
    add_row(i_type(12'h001, 5'd3, 3'h3, 5'd0, `DEC_OPC_SYS), EX_SFU, SFU_CSRRC, 32'h0,
            5'b0, 12'h001, 1'b0, 2'b01, 5'd0, 5'd3, 5'd0, 1'b1);
    // Warp control
    add_row(r_type(7'h00, 5'd0, 5'd1, 3'h0, 5'd0, `DEC_OPC_EXT1), EX_SFU, SFU_TMC, 32'h0,
            5'b0, 12'h000, 1'b0, 2'b01, 5'd0, 5'd1, 5'd0, 1'b0);
    add_row(r_type(7'h00, 5'd3, 5'd2, 3'h1, 5'd0, `DEC_OPC_EXT1), EX_SFU, SFU_WSPAWN, 32'h0,
            5'b0, 12'h000, 1'b0, 2'b11, 5'd0, 5'd2, 5'd3, 1'b0);
    add_row(r_type(7'h00, 5'd1, 5'd5, 3'h2, 5'd4, `DEC_OPC_EXT1), EX_SFU, SFU_SPLIT, 32'h0,
            fl_neg, 12'h000, 1'b1, 2'b01, 5'd4, 5'd5, 5'd0, 1'b0);
    add_row(r_type(7'h00, 5'd0, 5'd6, 3'h3, 5'd0, `DEC_OPC_EXT1), EX_SFU, SFU_JOIN, 32'h0,
            5'b0, 12'h000, 1'b0, 2'b01, 5'd0, 5'd6, 5'd0, 1'b0);
    add_row(r_type(7'h00, 5'd8, 5'd7, 3'h4, 5'd0, `DEC_OPC_EXT1), EX_SFU, SFU_BAR, 32'h0,
            5'b0, 12'h000, 1'b0, 2'b11, 5'd0, 5'd7, 5'd8, 1'b0);
    add_row(r_type(7'h00, 5'd10, 5'd9, 3'h5, 5'd3, `DEC_OPC_EXT1), EX_SFU, SFU_PRED, 32'h0,
            fl_neg, 12'h000, 1'b0, 2'b11, 5'd0, 5'd9, 5'd10, 1'b0);
    add_row(32'h0000_0000, EX_ALU, ALU_ADD, 32'h0,
            5'b0, 12'h000, 1'b0, 2'b00, 5'd0, 5'd0, 5'd0, 1'b1);  // Illegal opcode
endtask

//--- testbench/tb_decode.sv
`timescale 1ns/1ns
`include "decode_cfg.svh"

module tb_decode import decode_pkg::*; ();

    // op_args flag bits {use_imm, use_pc, xtype, is_store, is_neg}
    localparam logic [4:0] fl_imm = 5'b10000;
    localparam logic [4:0] fl_pc  = 5'b01000;
    localparam logic [4:0] fl_br  = 5'b00100;
    localparam logic [4:0] fl_st  = 5'b00010;
    localparam logic [4:0] fl_neg = 5'b00001;

    logic    clk;
    logic    arst_n;
    logic    fetch_valid;
    fetch_t  fetch_data;
    logic    fetch_ready;
    logic    decode_valid;
    decode_t decode_data;
    logic    decode_ready;
    logic    sched_valid;
    sched_t  sched_data;

    fetch_t  vec_fetch[$];
    decode_t vec_exp[$];
    logic    vec_unlock[$];
    decode_t exp_q[$];      // Scoreboard of accepted items
    decode_t cur_exp;
    logic    cur_unlock;
    decode_t held_data;
    logic    held_valid   = 1'b0;
    logic    random_ready = 1'b0;
    int      value_errors = 0;
    int      other_errors = 0;
    int      out_count    = 0;
    int      cycle_count  = 0;
    int      cycle_limit  = 0;

    decode_top DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch_valid  (fetch_valid),
        .fetch_data   (fetch_data),
        .fetch_ready  (fetch_ready),
        .decode_valid (decode_valid),
        .decode_data  (decode_data),
        .decode_ready (decode_ready),
        .sched_valid  (sched_valid),
        .sched_data   (sched_data)
    );

    function automatic instr_t r_type(input logic [6:0] f7, input reg_num_t rs2,
                                      input reg_num_t rs1, input logic [2:0] f3,
                                      input reg_num_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t i_type(input logic [11:0] imm, input reg_num_t rs1,
                                      input logic [2:0] f3, input reg_num_t rd,
                                      input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t s_type(input logic [11:0] imm, input reg_num_t rs2,
                                      input reg_num_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `DEC_OPC_S};
    endfunction

    function automatic instr_t b_type(input logic [12:0] imm, input reg_num_t rs2,
                                      input reg_num_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `DEC_OPC_B};
    endfunction

    function automatic instr_t u_type(input logic [19:0] imm, input reg_num_t rd,
                                      input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic instr_t j_type(input logic [20:0] imm, input reg_num_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `DEC_OPC_JAL};
    endfunction

    task automatic add_row(input instr_t instr, input ex_type_e ex, input op_t op,
                           input word_t imm, input logic [4:0] flags,
                           input logic [11:0] csr, input logic wb, input logic [1:0] used_rs,
                           input reg_num_t rd, input reg_num_t rs1, input reg_num_t rs2,
                           input logic unlock);
        fetch_t  f;
        decode_t d;
        int      n;
        n = vec_fetch.size();
        f.uuid  = uuid_t'(16'h0a00 + n);
        f.wid   = wid_t'(n);
        f.tmask = tmask_t'(n ^ 4'b1011);
        f.pc    = 32'h8000_0000 + word_t'(n) * 4;
        f.instr = instr;
        d.uuid  = f.uuid;
        d.wid   = f.wid;
        d.tmask = f.tmask;
        d.pc    = f.pc;
        d.ex_type = ex;
        d.op_type = op;
        d.op_args.imm      = imm;
        d.op_args.use_imm  = flags[4];
        d.op_args.use_pc   = flags[3];
        d.op_args.xtype    = alu_xtype_e'(flags[2]);
        d.op_args.is_store = flags[1];
        d.op_args.csr_addr = csr;
        d.op_args.is_neg   = flags[0];
        d.wb      = wb;
        d.used_rs = used_rs;
        d.rd      = rd;
        d.rs1     = rs1;
        d.rs2     = rs2;
        vec_fetch.push_back(f);
        vec_exp.push_back(d);
        vec_unlock.push_back(unlock);
    endtask

    `include "tb_decode_vectors.svh"

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got %b expected %b", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_sched(input sched_t got, input sched_t exp);
        check_field("sched_data.wid", got.wid, exp.wid);
        check_bit("sched_data.unlock", got.unlock, exp.unlock);
    endtask

    task automatic check_decode(input string ctx, input decode_t got, input decode_t exp);
        check_field({ctx, ".uuid"}, got.uuid, exp.uuid);
        check_field({ctx, ".wid"}, got.wid, exp.wid);
        check_field({ctx, ".tmask"}, got.tmask, exp.tmask);
        check_field({ctx, ".pc"}, got.pc, exp.pc);
        check_field({ctx, ".ex_type"}, got.ex_type, exp.ex_type);
        check_field({ctx, ".op_type"}, got.op_type, exp.op_type);
        check_field({ctx, ".imm"}, got.op_args.imm, exp.op_args.imm);
        check_field({ctx, ".use_imm"}, got.op_args.use_imm, exp.op_args.use_imm);
        check_field({ctx, ".use_pc"}, got.op_args.use_pc, exp.op_args.use_pc);
        check_field({ctx, ".xtype"}, got.op_args.xtype, exp.op_args.xtype);
        check_field({ctx, ".is_store"}, got.op_args.is_store, exp.op_args.is_store);
        check_field({ctx, ".csr_addr"}, got.op_args.csr_addr, exp.op_args.csr_addr);
        check_field({ctx, ".is_neg"}, got.op_args.is_neg, exp.op_args.is_neg);
        check_field({ctx, ".wb"}, got.wb, exp.wb);
        check_field({ctx, ".used_rs"}, got.used_rs, exp.used_rs);
        check_field({ctx, ".rd"}, got.rd, exp.rd);
        check_field({ctx, ".rs1"}, got.rs1, exp.rs1);
        check_field({ctx, ".rs2"}, got.rs2, exp.rs2);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : ready_drive
        void'($urandom(32'hc4ba37c3));
        forever begin
            @(negedge clk);
            if (random_ready)
                decode_ready = ($urandom % 3) != 0;  // Stall about one cycle in three
            else
                decode_ready = 1'b1;
        end
    end

    always @(posedge clk) begin : watchdog
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin : monitor
        logic    exp_valid;
        logic    exp_ready;
        logic    accept;
        decode_t front;
        sched_t  exp_sched;
        if (arst_n) begin
            exp_valid = exp_q.size() != 0;
            exp_ready = !exp_valid || decode_ready;
            accept    = fetch_valid && exp_ready;
            check_bit("decode_valid", decode_valid, exp_valid);
            check_bit("fetch_ready", fetch_ready, exp_ready);
            check_bit("sched_valid", sched_valid, accept);
            if (held_valid)
                check_decode("held decode_data", decode_data, held_data);
            if (decode_valid && decode_ready) begin
                if (exp_q.size() == 0) begin
                    $display("At %0t ns an item left the DUT with none pending", $time);
                    other_errors++;
                end else begin
                    front = exp_q.pop_front();
                    check_decode("decode_data", decode_data, front);
                    out_count++;
                end
            end
            if (accept) begin
                exp_sched.wid    = cur_exp.wid;
                exp_sched.unlock = cur_unlock;
                check_sched(sched_data, exp_sched);
                exp_q.push_back(cur_exp);
            end
            held_valid = exp_valid && !decode_ready;
            held_data  = decode_data;
        end
    end

    initial begin : stimulus
        fetch_t  fd;
        decode_t de;
        int      pass;
        int      i;
        arst_n       = 1'b0;
        fetch_valid  = 1'b0;
        fetch_data   = '0;
        decode_ready = 1'b1;
        load_vectors();
        cycle_limit = 2 * vec_fetch.size() * 8 + 100;  // Two passes over the table
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_bit("decode_valid after reset", decode_valid, 1'b0);
        check_bit("sched_valid after reset", sched_valid, 1'b0);
        // Pass 0 runs at full rate, pass 1 adds back-pressure and fetch gaps
        for (pass = 0; pass < 2; pass++) begin
            random_ready = (pass == 1);
            for (i = 0; i < vec_fetch.size(); i++) begin
                @(negedge clk);
                if (pass == 1 && i % 5 == 3) begin
                    fetch_valid = 1'b0;
                    @(negedge clk);
                end
                fd = vec_fetch[i];
                de = vec_exp[i];
                fd.uuid[15] = pass[0];  // Tell the passes apart
                de.uuid[15] = pass[0];
                cur_exp     = de;
                cur_unlock  = vec_unlock[i];
                fetch_data  = fd;
                fetch_valid = 1'b1;
                @(posedge clk);
                while (!fetch_ready) @(posedge clk);
            end
        end
        @(negedge clk);
        fetch_valid = 1'b0;
        while (exp_q.size() != 0 || decode_valid) @(negedge clk);
        if (out_count != 2 * vec_fetch.size()) begin
            $display("Expected %0d items at the decode output but saw %0d",
                     2 * vec_fetch.size(), out_count);
            other_errors++;
        end
        $display("Run complete: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
+incdir+testbench
src/decode_pkg.sv
src/imm_gen.sv
src/alu_op_decoder.sv
src/instr_decoder.sv
src/decode_pipe_reg.sv
src/decode_top.sv
testbench/tb_decode.sv
